//--- compile.f
+incdir+verif
design/soc_pkg.sv
design/addr_decoder.sv
design/sram_bank.sv
design/soc_ctrl_regs.sv
design/rsp_mux.sv
design/soc_mem_domain.sv
verif/tb_soc_mem_domain.sv

//--- design/addr_decoder.sv
module addr_decoder import soc_pkg::*; (
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [AddrWidth-1:0]          addr_i,
  input  logic [BeWidth-1:0]            be_i,
  input  logic [DataWidth-1:0]          wdata_i,

  output logic [NumSramBanks-1:0]       bank_req_o,
  output logic                          mem_we_o,
  output logic [BeWidth-1:0]            mem_be_o,
  output logic [DataWidth-1:0]          mem_wdata_o,
  output logic [SramBankAddrWidth-1:0]  mem_word_addr_o,

  output logic                          ctrl_req_o,
  output logic [SocCtrlOffsetWidth-1:0] ctrl_offset_o,

  output logic                          dec_valid_o,
  output target_e                       dec_target_o,
  output logic [BankIdxWidth-1:0]       dec_bank_o
);

  logic [AddrWidth-1:0] sram_offset;
  logic                 in_sram;
  logic                 in_ctrl;

  // ------------------------------------------------------------------
  // Address map
  // ------------------------------------------------------------------
  assign sram_offset = addr_i - SramBaseAddr;
  assign in_sram     = (addr_i >= SramBaseAddr) && (sram_offset < SramSize);
  assign in_ctrl     = addr_i[AddrWidth-1:SocCtrlOffsetWidth] ==
                       SocCtrlBaseAddr[AddrWidth-1:SocCtrlOffsetWidth];

  always_comb begin
    if (in_sram) begin
      dec_target_o = TGT_SRAM;
    end else if (in_ctrl) begin
      dec_target_o = TGT_SOC_CTRL;
    end else begin
      dec_target_o = TGT_ERROR;
    end
  end

  // Bank select sits just above the word index
  assign dec_bank_o  = sram_offset[ByteOffsetWidth+SramBankAddrWidth +: BankIdxWidth];
  assign dec_valid_o = req_i;

  // ------------------------------------------------------------------
  // Destination strobes
  // ------------------------------------------------------------------
  always_comb begin
    bank_req_o = '0;
    if (req_i && (dec_target_o == TGT_SRAM)) begin
      bank_req_o[dec_bank_o] = 1'b1;
    end
  end

  assign ctrl_req_o    = req_i && (dec_target_o == TGT_SOC_CTRL);
  assign ctrl_offset_o = addr_i[SocCtrlOffsetWidth-1:0];

  // Shared by all banks and the control block
  assign mem_word_addr_o = sram_offset[ByteOffsetWidth +: SramBankAddrWidth];
  assign mem_we_o        = we_i;
  assign mem_be_o        = be_i;
  assign mem_wdata_o     = wdata_i;

endmodule

//--- design/rsp_mux.sv
module rsp_mux import soc_pkg::*; (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,
  input  logic [NumSramBanks-1:0][DataWidth-1:0] bank_rdata_i,
  input  logic [DataWidth-1:0]                  ctrl_rdata_i,
  input  logic                                  dec_valid_i,
  input  target_e                               dec_target_i,
  input  logic [BankIdxWidth-1:0]               dec_bank_i,
  input  logic                                  dec_we_i,

  output logic                                  rvalid_o,
  output logic [DataWidth-1:0]                  rdata_o,
  output logic                                  err_o
);

  logic                    valid_q;
  target_e                 target_q;
  logic [BankIdxWidth-1:0] bank_q;
  logic                    we_q;

  // ------------------------------------------------------------------
  // Routing of the request in flight
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      target_q <= dec_target_i;
      bank_q   <= dec_bank_i;
      we_q     <= dec_we_i;
    end
  end

  // ------------------------------------------------------------------
  // Response select
  // ------------------------------------------------------------------
  always_comb begin
    rdata_o = '0;
    err_o   = 1'b0;
    if (valid_q) begin
      case (target_q)
        TGT_ERROR: begin
          rdata_o = ErrRspData;
          err_o   = 1'b1;
        end
        TGT_SOC_CTRL: begin
          if (!we_q) rdata_o = ctrl_rdata_i;
        end
        default: begin
          if (!we_q) rdata_o = bank_rdata_i[bank_q];
        end
      endcase
    end
  end

  assign rvalid_o = valid_q;

endmodule

//--- design/soc_ctrl_regs.sv
module soc_ctrl_regs import soc_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [BeWidth-1:0]            be_i,
  input  logic [SocCtrlOffsetWidth-1:0] offset_i,
  input  logic [DataWidth-1:0]          wdata_i,
  input  logic                          fetch_en_i,

  output logic [DataWidth-1:0]          rdata_o,
  output logic                          fetch_enable_o,
  output logic [AddrWidth-1:0]          boot_addr_o,
  output logic                          sram_impl_o
);

  logic                 fetchen_q;
  logic [AddrWidth-1:0] bootaddr_q;
  logic                 sram_dly_q;

  logic                 wr_fetchen;
  logic                 wr_bootaddr;
  logic                 wr_sram_dly;
  logic [DataWidth-1:0] rdata_d;

  // ------------------------------------------------------------------
  // Register writes
  // ------------------------------------------------------------------
  assign wr_fetchen  = req_i && we_i && (offset_i == SocCtrlFetchEnOffset);
  assign wr_bootaddr = req_i && we_i && (offset_i == SocCtrlBootAddrOffset);
  assign wr_sram_dly = req_i && we_i && (offset_i == SocCtrlSramDlyOffset);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      fetchen_q  <= 1'b0;
      bootaddr_q <= SramBaseAddr;
      sram_dly_q <= 1'b0;
    end else begin
      // Single-bit fields live in byte lane 0
      if (wr_fetchen && be_i[0]) begin
        fetchen_q <= wdata_i[0];
      end
      if (wr_bootaddr) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (be_i[b]) begin
            bootaddr_q[b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
      if (wr_sram_dly && be_i[0]) begin
        sram_dly_q <= wdata_i[0];
      end
    end
  end

  // ------------------------------------------------------------------
  // Register reads
  // ------------------------------------------------------------------
  always_comb begin
    case (offset_i)
      SocCtrlFetchEnOffset:  rdata_d = DataWidth'(fetchen_q);
      SocCtrlBootAddrOffset: rdata_d = DataWidth'(bootaddr_q);
      SocCtrlSramDlyOffset:  rdata_d = DataWidth'(sram_dly_q);
      default:               rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= rdata_d;
    end
  end

  // Pin can force fetch on regardless of software
  assign fetch_enable_o = fetchen_q | fetch_en_i;
  assign boot_addr_o    = bootaddr_q;
  assign sram_impl_o    = sram_dly_q;

endmodule

//--- design/soc_mem_domain.sv
module soc_mem_domain import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Manager request
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic [DataWidth-1:0] wdata_i,

  // Manager response
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 err_o,

  // SoC control
  input  logic                 fetch_en_i,
  output logic                 fetch_enable_o,
  output logic [AddrWidth-1:0] boot_addr_o,
  output logic                 sram_impl_o
);

  // ------------------------------------------------------------------
  // Decoded request
  // ------------------------------------------------------------------
  logic [NumSramBanks-1:0]              bank_req;
  logic                                 mem_we;
  logic [BeWidth-1:0]                   mem_be;
  logic [DataWidth-1:0]                 mem_wdata;
  logic [SramBankAddrWidth-1:0]         mem_word_addr;
  logic                                 ctrl_req;
  logic [SocCtrlOffsetWidth-1:0]        ctrl_offset;
  logic                                 dec_valid;
  target_e                              dec_target;
  logic [BankIdxWidth-1:0]              dec_bank;

  // Read data back to the mux
  logic [NumSramBanks-1:0][DataWidth-1:0] bank_rdata;
  logic [DataWidth-1:0]                   ctrl_rdata;

  addr_decoder i_addr_decoder (
    .req_i           ( req_i         ),
    .we_i            ( we_i          ),
    .addr_i          ( addr_i        ),
    .be_i            ( be_i          ),
    .wdata_i         ( wdata_i       ),
    .bank_req_o      ( bank_req      ),
    .mem_we_o        ( mem_we        ),
    .mem_be_o        ( mem_be        ),
    .mem_wdata_o     ( mem_wdata     ),
    .mem_word_addr_o ( mem_word_addr ),
    .ctrl_req_o      ( ctrl_req      ),
    .ctrl_offset_o   ( ctrl_offset   ),
    .dec_valid_o     ( dec_valid     ),
    .dec_target_o    ( dec_target    ),
    .dec_bank_o      ( dec_bank      )
  );

  // ------------------------------------------------------------------
  // Memories
  // ------------------------------------------------------------------
  for (genvar i = 0; i < NumSramBanks; i++) begin : gen_sram_bank
    sram_bank i_sram_bank (
      .clk_i       ( clk_i         ),
      .req_i       ( bank_req[i]   ),
      .we_i        ( mem_we        ),
      .be_i        ( mem_be        ),
      .word_addr_i ( mem_word_addr ),
      .wdata_i     ( mem_wdata     ),
      .rdata_o     ( bank_rdata[i] )
    );
  end

  // ------------------------------------------------------------------
  // SoC control and response path
  // ------------------------------------------------------------------
  soc_ctrl_regs i_soc_ctrl_regs (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .req_i          ( ctrl_req       ),
    .we_i           ( mem_we         ),
    .be_i           ( mem_be         ),
    .offset_i       ( ctrl_offset    ),
    .wdata_i        ( mem_wdata      ),
    .fetch_en_i     ( fetch_en_i     ),
    .rdata_o        ( ctrl_rdata     ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    ),
    .sram_impl_o    ( sram_impl_o    )
  );

  rsp_mux i_rsp_mux (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .bank_rdata_i ( bank_rdata ),
    .ctrl_rdata_i ( ctrl_rdata ),
    .dec_valid_i  ( dec_valid  ),
    .dec_target_i ( dec_target ),
    .dec_bank_i   ( dec_bank   ),
    .dec_we_i     ( mem_we     ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      )
  );

endmodule

//--- design/soc_pkg.sv
package soc_pkg;

  // ------------------------------------------------------------------
  // Bus geometry
  // ------------------------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = DataWidth / 8;

  // Byte address bits below the word index
  localparam int unsigned ByteOffsetWidth = $clog2(BeWidth);

  // ------------------------------------------------------------------
  // SRAM banks
  // ------------------------------------------------------------------
  localparam int unsigned NumSramBanks      = 2;
  localparam int unsigned SramBankNumWords  = 256;
  localparam int unsigned SramBankAddrWidth = $clog2(SramBankNumWords);
  localparam int unsigned BankIdxWidth      = (NumSramBanks > 1) ? $clog2(NumSramBanks) : 1;

  // 1 KiB per bank
  localparam int unsigned SramBankBytes = SramBankNumWords * BeWidth;

  localparam logic [AddrWidth-1:0] SramBaseAddr = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] SramSize     = AddrWidth'(NumSramBanks * SramBankBytes);

  // ------------------------------------------------------------------
  // SoC control registers
  // ------------------------------------------------------------------
  localparam logic [AddrWidth-1:0] SocCtrlBaseAddr = 32'h0300_0000;

  // 4 KiB window
  localparam int unsigned SocCtrlOffsetWidth = 12;

  localparam logic [SocCtrlOffsetWidth-1:0] SocCtrlFetchEnOffset  = 12'h000;
  localparam logic [SocCtrlOffsetWidth-1:0] SocCtrlBootAddrOffset = 12'h004;
  localparam logic [SocCtrlOffsetWidth-1:0] SocCtrlSramDlyOffset  = 12'h008;

  // ------------------------------------------------------------------
  // Response
  // ------------------------------------------------------------------
  // Read data returned for unmapped space
  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADC_AB1E;

  // Destination of a decoded request
  typedef enum logic [1:0] {
    TGT_SRAM,
    TGT_SOC_CTRL,
    TGT_ERROR
  } target_e;

endpackage

//--- design/sram_bank.sv
module sram_bank import soc_pkg::*; (
  input  logic                         clk_i,
  input  logic                         req_i,
  input  logic                         we_i,
  input  logic [BeWidth-1:0]           be_i,
  input  logic [SramBankAddrWidth-1:0] word_addr_i,
  input  logic [DataWidth-1:0]         wdata_i,
  output logic [DataWidth-1:0]         rdata_o
);

  // Word array with undefined contents after power-up
  logic [DataWidth-1:0] mem_q [SramBankNumWords];

  // ------------------------------------------------------------------
  // Write port with byte lanes
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[word_addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------------
  // Output latch holds the last read word between reads
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[word_addr_i];
    end
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the memory domain testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_soc_mem_domain
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module "$TOP" --Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Verdict comes from the log
grep -q -x -F ">>> PASS" "$LOG"
if [ $? -ne 0 ]; then
  echo "Pass message not found in $LOG"
  exit 1
fi

echo "Simulation passed"
exit 0

//--- verif/tb_vectors.svh
    // Column order is name, we, addr, be, wdata, fetch_en pin,
    // exp rdata, exp err, exp fetchen reg, exp boot_addr, exp sram_impl

    // Boot address reads its reset value
    add_vec("rd_boot_rst",    0, 'h03000004, 'hF, 'h0,        0, 'h10000000, 0, 0, 'h10000000, 0);

    // Bank 0 and bank 1 interleaved back to back
    add_vec("wr_b0_w0",       1, 'h10000000, 'hF, 'h11223344, 0, 'h0,        0, 0, 'h10000000, 0);
    add_vec("wr_b1_w0",       1, 'h10000400, 'hF, 'h55667788, 0, 'h0,        0, 0, 'h10000000, 0);
    add_vec("wr_b0_w5",       1, 'h10000014, 'hF, 'hA5A50F0F, 0, 'h0,        0, 0, 'h10000000, 0);
    add_vec("wr_b1_wff",      1, 'h100007FC, 'hF, 'hDEADBEEF, 0, 'h0,        0, 0, 'h10000000, 0);
    add_vec("rd_b0_w0",       0, 'h10000000, 'hF, 'h0,        0, 'h11223344, 0, 0, 'h10000000, 0);
    add_vec("rd_b1_w0",       0, 'h10000400, 'hF, 'h0,        0, 'h55667788, 0, 0, 'h10000000, 0);
    add_vec("rd_b0_w5",       0, 'h10000014, 'hF, 'h0,        0, 'hA5A50F0F, 0, 0, 'h10000000, 0);
    add_vec("rd_b1_wff",      0, 'h100007FC, 'hF, 'h0,        0, 'hDEADBEEF, 0, 0, 'h10000000, 0);

    // Partial writes to lanes 0 and 2 and then to lane 3 only
    add_vec("wr_b0_w0_be5",   1, 'h10000000, 'h5, 'hCAFEF00D, 0, 'h0,        0, 0, 'h10000000, 0);
    add_vec("wr_b1_w0_be8",   1, 'h10000400, 'h8, 'h99AABBCC, 0, 'h0,        0, 0, 'h10000000, 0);
    add_vec("rd_b0_w0_be",    0, 'h10000000, 'hF, 'h0,        0, 'h11FE330D, 0, 0, 'h10000000, 0);
    add_vec("rd_b1_w0_be",    0, 'h10000400, 'hF, 'h0,        0, 'h99667788, 0, 0, 'h10000000, 0);

    // Control registers
    add_vec("wr_fetchen",     1, 'h03000000, 'hF, 'h1,        0, 'h0,        0, 1, 'h10000000, 0);
    add_vec("rd_fetchen",     0, 'h03000000, 'hF, 'h0,        0, 'h1,        0, 1, 'h10000000, 0);
    add_vec("wr_boot",        1, 'h03000004, 'hF, 'h10000200, 0, 'h0,        0, 1, 'h10000200, 0);
    add_vec("wr_boot_b2",     1, 'h03000004, 'h4, 'h00550000, 0, 'h0,        0, 1, 'h10550200, 0);
    add_vec("rd_boot",        0, 'h03000004, 'hF, 'h0,        0, 'h10550200, 0, 1, 'h10550200, 0);
    add_vec("rd_ctrl_hole",   0, 'h0300000C, 'hF, 'h0,        0, 'h0,        0, 1, 'h10550200, 0);
    add_vec("wr_sram_dly",    1, 'h03000008, 'hF, 'h1,        0, 'h0,        0, 1, 'h10550200, 1);
    add_vec("rd_sram_dly",    0, 'h03000008, 'hF, 'h0,        0, 'h1,        0, 1, 'h10550200, 1);
    add_vec("wr_fetchen_clr", 1, 'h03000000, 'hF, 'h0,        1, 'h0,        0, 0, 'h10550200, 1);
    add_vec("rd_fetchen_pin", 0, 'h03000000, 'hF, 'h0,        1, 'h0,        0, 0, 'h10550200, 1);

    // Unmapped accesses followed by reads of SRAM words that a leak would hit
    add_vec("rd_err_low",     0, 'h00000000, 'hF, 'h0,        0, 'hBADCAB1E, 1, 0, 'h10550200, 1);
    add_vec("wr_err_gap",     1, 'h10000800, 'hF, 'hFFFFFFFF, 0, 'hBADCAB1E, 1, 0, 'h10550200, 1);
    add_vec("wr_err_below",   1, 'h0FFFFFFC, 'hF, 'h0,        0, 'hBADCAB1E, 1, 0, 'h10550200, 1);
    add_vec("rd_b0_w0_chk",   0, 'h10000000, 'hF, 'h0,        0, 'h11FE330D, 0, 0, 'h10550200, 1);
    add_vec("rd_b1_wff_chk",  0, 'h100007FC, 'hF, 'h0,        0, 'hDEADBEEF, 0, 0, 'h10550200, 1);

//--- verif/tb_soc_mem_domain.sv
module tb_soc_mem_domain import soc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned ResetCycles = 16;

  typedef struct {
    string                name;
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
    logic                 fetch_en;
    logic [DataWidth-1:0] exp_rdata;
    logic                 exp_err;
    logic                 exp_fetchen;
    logic [AddrWidth-1:0] exp_boot;
    logic                 exp_impl;
  } vec_t;

  logic                 clk;
  logic                 rst_n;
  logic                 req;
  logic                 we;
  logic [AddrWidth-1:0] addr;
  logic [BeWidth-1:0]   be;
  logic [DataWidth-1:0] wdata;
  logic                 fetch_en;
  logic                 rvalid;
  logic [DataWidth-1:0] rdata;
  logic                 err;
  logic                 fetch_enable;
  logic [AddrWidth-1:0] boot_addr;
  logic                 sram_impl;

  vec_t        vecs[$];
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  always #4 clk = ~clk;

  soc_mem_domain soc_mem_domain_i (
    .clk_i          ( clk          ),
    .rst_n_i        ( rst_n        ),
    .req_i          ( req          ),
    .we_i           ( we           ),
    .addr_i         ( addr         ),
    .be_i           ( be           ),
    .wdata_i        ( wdata        ),
    .rvalid_o       ( rvalid       ),
    .rdata_o        ( rdata        ),
    .err_o          ( err          ),
    .fetch_en_i     ( fetch_en     ),
    .fetch_enable_o ( fetch_enable ),
    .boot_addr_o    ( boot_addr    ),
    .sram_impl_o    ( sram_impl    )
  );

  // ------------------------------------------------------------------
  // Vector table
  // ------------------------------------------------------------------
  function automatic void add_vec(string name, bit [31:0] we_v, bit [31:0] addr_v,
                                  bit [31:0] be_v, bit [31:0] wdata_v, bit [31:0] pin_v,
                                  bit [31:0] rdata_v, bit [31:0] err_v, bit [31:0] fetchen_v,
                                  bit [31:0] boot_v, bit [31:0] impl_v);
    vec_t v;
    v.name        = name;
    v.we          = we_v[0];
    v.addr        = addr_v;
    v.be          = be_v[BeWidth-1:0];
    v.wdata       = wdata_v;
    v.fetch_en    = pin_v[0];
    v.exp_rdata   = rdata_v;
    v.exp_err     = err_v[0];
    v.exp_fetchen = fetchen_v[0];
    v.exp_boot    = boot_v;
    v.exp_impl    = impl_v[0];
    vecs.push_back(v);
  endfunction

  function automatic void load_table();
`include "tb_vectors.svh"
  endfunction

  // ------------------------------------------------------------------
  // Drive and check
  // ------------------------------------------------------------------
  task automatic check_value(string test, string what, logic [31:0] exp, logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s: %s expected 0x%08h actual 0x%08h", test, what, exp, act);
      $display(">>> FAIL");
      $fatal(1, "Mismatch on %s in %s", what, test);
    end
  endtask

  task automatic drive_entry(vec_t v);
    req      <= 1'b1;
    we       <= v.we;
    addr     <= v.addr;
    be       <= v.be;
    wdata    <= v.wdata;
    fetch_en <= v.fetch_en;
  endtask

  task automatic drive_idle();
    req      <= 1'b0;
    we       <= 1'b0;
    addr     <= '0;
    be       <= '0;
    wdata    <= '0;
    fetch_en <= 1'b0;
  endtask

  // Pin value is whatever is driven in the response cycle
  task automatic check_response(vec_t v);
    check_value(v.name, "rvalid", 32'h1, 32'(rvalid));
    check_value(v.name, "err", 32'(v.exp_err), 32'(err));
    check_value(v.name, "rdata", v.exp_rdata, rdata);
    check_value(v.name, "fetch_enable", 32'(v.exp_fetchen | fetch_en), 32'(fetch_enable));
    check_value(v.name, "boot_addr", v.exp_boot, boot_addr);
    check_value(v.name, "sram_impl", 32'(v.exp_impl), 32'(sram_impl));
  endtask

  // ------------------------------------------------------------------
  // Timeout
  // ------------------------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  initial begin
    int n;
    clk         = 1'b0;
    rst_n       = 1'b0;
    req         = 1'b0;
    we          = 1'b0;
    addr        = '0;
    be          = '0;
    wdata       = '0;
    fetch_en    = 1'b0;
    cycle_cnt   = 0;
    load_table();
    n           = vecs.size();
    cycle_limit = ResetCycles + 2 * n + 20;

    // Unmapped reads and a toggling pin while reset is held
    for (int c = 0; c < ResetCycles; c++) begin
      @(posedge clk);
      fetch_en <= c[0];
      if (c == ResetCycles - 1) begin
        req   <= 1'b0;
        rst_n <= 1'b1;
      end else begin
        req <= 1'b1;
      end
      @(negedge clk);
      check_value("reset", "rvalid", '0, 32'(rvalid));
      check_value("reset", "err", '0, 32'(err));
      check_value("reset", "boot_addr", SramBaseAddr, boot_addr);
      check_value("reset", "sram_impl", '0, 32'(sram_impl));
      check_value("reset", "fetch_enable", 32'(fetch_en), 32'(fetch_enable));
    end

    // One entry per cycle with its response checked a cycle later
    for (int j = 0; j <= n; j++) begin
      @(posedge clk);
      if (j < n) begin
        drive_entry(vecs[j]);
      end else begin
        drive_idle();
      end
      @(negedge clk);
      if (j == 0) begin
        check_value("idle", "rvalid", '0, 32'(rvalid));
      end else begin
        check_response(vecs[j-1]);
      end
    end

    $display(">>> PASS");
    $finish;
  end

endmodule
